// ==== files.f ====
hw/link_pkg.sv
hw/game_pkg.sv
hw/serial_deframer.sv
hw/frame_sequencer.sv
hw/data_packet_tracker.sv
hw/handshake_decoder.sv
hw/link_receiver.sv
verif/link_receiver_assertions.sv
verif/link_receiver_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = link_receiver_tb
FILELIST = files.f
RUNFLAGS = +verilator+error+limit+1000

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx 'All tests passed!'

clean:
	rm -rf obj_dir

// ==== verif/link_receiver_tb.sv ====
// ----------------------------------------------------------
// link_receiver testbench, frame serializer, model, tests
// ----------------------------------------------------------
`timescale 1ns/1ps

module link_receiver_tb
	import link_pkg::*,
	       game_pkg::*;
();

	// frames, ack waits, game restarts and margin
	localparam int TIMEOUT_CYCLES = 10 * 48 + 6 * (ACK_DELAY + 20) + 600;

	logic clk = 1'b0;
	logic rst_l, game_active, init_seq, serial_h;
	lanes_t serial_d;
	logic update_opponent_data, send_ack, ack_seq, ack_received;
	logic ack_seq_received, opponent_lost, send_lost_ack;
	garbage_t opponent_garbage;
	tile_t opponent_hold;
	queue_t opponent_queue;
	playfield_t opponent_playfield;

	// model state read by the bound checks
	int cyc = 0;
	logic expect_update, exp_seq, exp_is_ack, exp_ack_seq_rx;
	logic [59:0] exp_fields;
	int exp_update_cyc, exp_ack_cyc, exp_hnd_cyc;

	int seed;
	// pulse counts of update, send_ack, ack_received and send_lost_ack
	int seen [4];
	int base [4];
	int test_num = 0;
	int test_errs, err_base, passed, failed;

	link_receiver i_link_receiver (.*);

	bind link_receiver link_receiver_assertions i_checks (
		.clk(clk), .rst_l(rst_l), .game_active(game_active), .init_seq(init_seq),
		.update_opponent_data(update_opponent_data), .opponent_garbage(opponent_garbage),
		.opponent_hold(opponent_hold), .opponent_queue(opponent_queue),
		.opponent_playfield(opponent_playfield), .send_ack(send_ack), .ack_seq(ack_seq),
		.ack_received(ack_received), .ack_seq_received(ack_seq_received),
		.opponent_lost(opponent_lost), .send_lost_ack(send_lost_ack)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	// pulses counted mid-cycle, away from the edges
	always @(negedge clk) begin
		if (update_opponent_data) seen[0]++;
		if (send_ack) seen[1]++;
		if (ack_received) seen[2]++;
		if (send_lost_ack) seen[3]++;
	end

	// seq bit is 1 when at least two of four bits are set
	function automatic logic vote4(input logic [3:0] code);
		return (code[0] + code[1] + code[2] + code[3]) >= 2;
	endfunction

	// noise must not form the sync word before the real one,
	// starting from an all-zero hunt window
	function automatic bit noise_ok(input logic [11:0] noise);
		logic [27:0] v;
		v = {8'h00, noise, SYNC_WORD};
		for (int k = 0; k < 20; k++) begin
			if (v[27-k -: 8] == SYNC_WORD) return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic drive_bits(input bit to_hnd, input logic [3:0] bits);
		@(posedge clk);
		#1;
		if (to_hnd) serial_h = bits[0];
		else serial_d = bits;
	endtask

	// noise, sync word and payload msb first
	// last_cyc holds the drive cycle of the last payload bit
	task automatic send_frame(input bit to_hnd, input logic [63:0] pay, input int nbits,
			output int last_cyc);
		logic [11:0] noise;
		logic [3:0] bits;
		noise = 12'($random(seed));
		while (!noise_ok(noise)) noise = 12'($random(seed));
		for (int i = 11; i >= 0; i--) drive_bits(to_hnd, {4{noise[i]}});
		for (int i = 7; i >= 0; i--) drive_bits(to_hnd, {4{SYNC_WORD[i]}});
		for (int j = 0; j < nbits; j++) begin
			if (to_hnd) begin
				bits = {4{pay[nbits-1-j]}};
			end else begin
				for (int l = 0; l < 4; l++) bits[l] = pay[(3-l)*16 + 15 - j];
			end
			drive_bits(to_hnd, bits);
		end
		last_cyc = cyc;
	endtask

	task automatic send_packet(input logic [3:0] code, input logic [59:0] body);
		int n;
		send_frame(1'b0, {code, body}, 16, n);
		exp_ack_cyc = n + 4 + ACK_DELAY;
		expect_update = (vote4(code) == exp_seq);
		if (expect_update) begin
			// garbage, hold, queue, playfield below the seq code
			exp_fields = {body[59:56], body[55:52], body[51:40], body[39:0]};
			exp_update_cyc = n + 5;
			exp_seq = ~exp_seq;
		end
		repeat (4) drive_bits(1'b0, 4'h0);
	endtask

	task automatic send_hnd(input logic [3:0] seq_code, input logic [3:0] type_code);
		int n;
		send_frame(1'b1, {56'h0, seq_code, type_code}, 8, n);
		exp_is_ack = |type_code;
		exp_ack_seq_rx = vote4(seq_code);
		exp_hnd_cyc = n + 5;
		repeat (4) drive_bits(1'b1, 4'h0);
	endtask

	task automatic restart_game(input logic new_init);
		@(posedge clk);
		#1 game_active = 1'b0;
		expect_update = 1'b0;
		exp_fields = '0;
		repeat (3) @(posedge clk);
		#1 init_seq = new_init;
		exp_seq = new_init;
		repeat (3) @(posedge clk);
		#1 game_active = 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic wait_count(input int which, input int delta, input int limit,
			input string what);
		int k;
		k = 0;
		while (seen[which] < base[which] + delta && k < limit) begin
			@(posedge clk);
			k++;
		end
		if (seen[which] < base[which] + delta) begin
			$display("test %0d: %s did not arrive within %0d cycles", test_num, what, limit);
			test_errs++;
		end
	endtask

	task automatic expect_count(input int which, input int delta, input string what);
		repeat (10) @(posedge clk);
		if (seen[which] != base[which] + delta) begin
			$display("MISMATCH %0t: test %0d expected %0d %s pulses, got %0d", $time,
				test_num, delta, what, seen[which] - base[which]);
			test_errs++;
		end
	endtask

	task automatic start_test();
		test_num++;
		test_errs = 0;
		err_base = i_link_receiver.i_checks.err_cnt;
		base = seen;
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0 && i_link_receiver.i_checks.err_cnt == err_base) begin
			passed++;
			$display("test %0d %s: ok", test_num, name);
		end else begin
			failed++;
			$display("test %0d %s: FAILED", test_num, name);
		end
	endtask

	initial begin
		seed = 32'h79828710;
		passed = 0;
		failed = 0;
		rst_l = 1'b0;
		game_active = 1'b0;
		init_seq = 1'b1;
		serial_h = 1'b0;
		serial_d = '0;
		expect_update = 1'b0;
		exp_seq = 1'b1;
		exp_fields = '0;
		exp_is_ack = 1'b1;
		exp_ack_seq_rx = 1'b0;
		exp_update_cyc = -1;
		exp_ack_cyc = -1;
		exp_hnd_cyc = -1;
		repeat (10) @(posedge clk);
		#1 rst_l = 1'b1;

		start_test();
		repeat (8) @(posedge clk);
		end_test("idle after reset");
		#1 game_active = 1'b1;
		repeat (4) @(posedge clk);

		// init_seq 1 and a two-bit code that votes 1
		start_test();
		send_packet(4'b1001, 60'h3_7_A5C_0123456789);
		wait_count(0, 1, 20, "update_opponent_data");
		wait_count(1, 1, ACK_DELAY + 20, "send_ack");
		expect_count(1, 1, "send_ack");
		end_test("in-sequence packet");

		// expected 0 with a two-bit code voting 1
		// then expected 1 with a one-bit code voting 0
		start_test();
		send_packet(4'b0110, 60'h9_2_111_FEDCBA9876);
		wait_count(1, 1, ACK_DELAY + 30, "send_ack");
		restart_game(1'b1);
		send_packet(4'b0100, 60'h5_5_222_0F0F0F0F0F);
		wait_count(1, 2, ACK_DELAY + 30, "send_ack");
		expect_count(0, 0, "update_opponent_data");
		expect_count(1, 2, "send_ack");
		end_test("out-of-sequence packets");

		start_test();
		send_hnd(4'b1011, 4'b0100);
		wait_count(2, 1, 40, "ack_received");
		send_hnd(4'b0001, 4'b1111);
		wait_count(2, 2, 40, "ack_received");
		expect_count(3, 0, "send_lost_ack");
		end_test("handshake ack");

		start_test();
		send_hnd(4'b0110, 4'b0000);
		wait_count(3, 1, 40, "send_lost_ack");
		// a repeated game over frame gets no second lost ack
		send_hnd(4'b1001, 4'b0000);
		expect_count(3, 1, "send_lost_ack");
		restart_game(1'b0);
		end_test("game over");

		// expected 0 then 1 with one and three set bits
		start_test();
		send_packet(4'b0001, 60'hC_A_345_1122334455);
		send_packet(4'b1110, 60'h1_F_678_AABBCCDDEE);
		wait_count(0, 2, 20, "update_opponent_data");
		wait_count(1, 1, ACK_DELAY + 20, "send_ack");
		expect_count(1, 1, "send_ack");
		end_test("back-to-back packets");

		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0 && i_link_receiver.i_checks.err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== verif/link_receiver_assertions.sv ====
// ----------------------------------------------------------
// bound checks of link_receiver outputs against the tb model
// ----------------------------------------------------------
`timescale 1ns/1ps

module link_receiver_assertions
	import game_pkg::*;
(
	input logic       clk,
	input logic       rst_l,
	input logic       game_active,
	input logic       init_seq,
	input logic       update_opponent_data,
	input garbage_t   opponent_garbage,
	input tile_t      opponent_hold,
	input queue_t     opponent_queue,
	input playfield_t opponent_playfield,
	input logic       send_ack,
	input logic       ack_seq,
	input logic       ack_received,
	input logic       ack_seq_received,
	input logic       opponent_lost,
	input logic       send_lost_ack
);
	// failure count, polled by the tb at the end of each test
	int err_cnt = 0;
	logic [59:0] fields;
	logic pulses;

	assign fields = {opponent_garbage, opponent_hold, opponent_queue, opponent_playfield};
	assign pulses = update_opponent_data | send_ack | ack_received | send_lost_ack;

	// one cycle after game_active low everything is back at reset values
	a_idle: assert property (@(posedge clk) disable iff (!rst_l)
		!$past(game_active) |-> !pulses && !opponent_lost && fields == '0 && ack_seq == init_seq)
		else begin
			err_cnt++;
			$error("MISMATCH %0t: outputs not at reset values while idle", $time);
		end

	// update only for in-sequence packets, 5 cycles after the last bit
	a_update: assert property (@(posedge clk) disable iff (!rst_l)
		update_opponent_data |-> link_receiver_tb.expect_update
			&& link_receiver_tb.cyc == link_receiver_tb.exp_update_cyc
			&& fields == link_receiver_tb.exp_fields
			&& ack_seq == link_receiver_tb.exp_seq)
		else begin
			err_cnt++;
			$error("MISMATCH %0t: opponent update wrong in time, fields or seq", $time);
		end

	// fields and ack_seq move only with an update
	a_hold: assert property (@(posedge clk) disable iff (!rst_l)
		($changed(fields) || $changed(ack_seq)) && $past(game_active) |-> update_opponent_data)
		else begin
			err_cnt++;
			$error("MISMATCH %0t: opponent state changed without update", $time);
		end

	a_ack_time: assert property (@(posedge clk) disable iff (!rst_l)
		send_ack |-> link_receiver_tb.cyc == link_receiver_tb.exp_ack_cyc)
		else begin
			err_cnt++;
			$error("MISMATCH %0t: send_ack at wrong cycle", $time);
		end

	a_ack_rx: assert property (@(posedge clk) disable iff (!rst_l)
		ack_received |-> link_receiver_tb.exp_is_ack
			&& link_receiver_tb.cyc == link_receiver_tb.exp_hnd_cyc
			&& ack_seq_received == link_receiver_tb.exp_ack_seq_rx)
		else begin
			err_cnt++;
			$error("MISMATCH %0t: ack_received or ack_seq_received wrong", $time);
		end

	// game over sets the sticky flag, lost ack fires with it
	a_lost: assert property (@(posedge clk) disable iff (!rst_l)
		$rose(opponent_lost) |-> !link_receiver_tb.exp_is_ack
			&& link_receiver_tb.cyc == link_receiver_tb.exp_hnd_cyc && send_lost_ack)
		else begin
			err_cnt++;
			$error("MISMATCH %0t: opponent_lost rose unexpectedly", $time);
		end

	a_lost_ack: assert property (@(posedge clk) disable iff (!rst_l)
		send_lost_ack |-> $rose(opponent_lost))
		else begin
			err_cnt++;
			$error("MISMATCH %0t: send_lost_ack without new game over", $time);
		end

	a_sticky: assert property (@(posedge clk) disable iff (!rst_l)
		$fell(opponent_lost) |-> !$past(game_active))
		else begin
			err_cnt++;
			$error("MISMATCH %0t: opponent_lost cleared during a game", $time);
		end

endmodule

// ==== hw/link_receiver.sv ====
// ----------------------------------------------------------
// link receiver top, input synchronizers, deframers,
// sequencers, packet tracker and handshake decoder
// ----------------------------------------------------------
`timescale 1ns/1ps

module link_receiver
	import link_pkg::*,
	       game_pkg::*;
(
	input  logic       clk,
	input  logic       rst_l,
	input  logic       game_active,
	input  logic       init_seq,
	input  logic       serial_h,
	input  lanes_t     serial_d,
	output logic       update_opponent_data,
	output garbage_t   opponent_garbage,
	output tile_t      opponent_hold,
	output queue_t     opponent_queue,
	output playfield_t opponent_playfield,
	output logic       send_ack,
	output logic       ack_seq,
	output logic       ack_received,
	output logic       ack_seq_received,
	output logic       opponent_lost,
	output logic       send_lost_ack
);
	// handshake line in the top bit, data lanes below
	logic [DATA_LANES:0] line_meta;
	logic [DATA_LANES:0] line_sync;

	logic data_start;
	logic data_valid;
	lanes_t data_done;
	data_frame_t data_frame [DATA_LANES];
	data_packet_t packet;

	logic hnd_start;
	logic hnd_valid;
	logic hnd_done;
	hnd_frame_t hnd_frame;

	// two flop synchronizers
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			line_meta <= '0;
			line_sync <= '0;
		end else begin
			line_meta <= {serial_h, serial_d};
			line_sync <= line_meta;
		end
	end

	// data lanes share one sequencer
	frame_sequencer #(.LANES(DATA_LANES)) i_data_seq (
		.clk(clk),
		.rst_l(rst_l),
		.game_active(game_active),
		.done_lanes(data_done),
		.start(data_start),
		.frame_valid(data_valid)
	);

	for (genvar i = 0; i < DATA_LANES; i++) begin : g_lane
		serial_deframer #(.FRAME_BITS(DATA_FRAME_BITS)) i_deframer (
			.clk(clk),
			.rst_l(rst_l),
			.start(data_start),
			.serial(line_sync[i]),
			.frame(data_frame[i]),
			.done(data_done[i])
		);
		// lane 0 at the top of the packet
		assign packet[(DATA_LANES-1-i)*DATA_FRAME_BITS +: DATA_FRAME_BITS] = data_frame[i];
	end

	// handshake lane
	frame_sequencer #(.LANES(1)) i_hnd_seq (
		.clk(clk),
		.rst_l(rst_l),
		.game_active(game_active),
		.done_lanes(hnd_done),
		.start(hnd_start),
		.frame_valid(hnd_valid)
	);

	serial_deframer #(.FRAME_BITS(HND_FRAME_BITS)) i_hnd_deframer (
		.clk(clk),
		.rst_l(rst_l),
		.start(hnd_start),
		.serial(line_sync[DATA_LANES]),
		.frame(hnd_frame),
		.done(hnd_done)
	);

	data_packet_tracker i_tracker (
		.clk(clk),
		.rst_l(rst_l),
		.game_active(game_active),
		.init_seq(init_seq),
		.packet(packet),
		.packet_valid(data_valid),
		.update_opponent_data(update_opponent_data),
		.opponent_garbage(opponent_garbage),
		.opponent_hold(opponent_hold),
		.opponent_queue(opponent_queue),
		.opponent_playfield(opponent_playfield),
		.send_ack(send_ack),
		.ack_seq(ack_seq)
	);

	handshake_decoder i_hnd_decoder (
		.clk(clk),
		.rst_l(rst_l),
		.game_active(game_active),
		.frame(hnd_frame),
		.frame_valid(hnd_valid),
		.ack_received(ack_received),
		.ack_seq_received(ack_seq_received),
		.opponent_lost(opponent_lost),
		.send_lost_ack(send_lost_ack)
	);

endmodule

// ==== hw/handshake_decoder.sv ====
// ----------------------------------------------------------
// handshake frame decode into ack and game over events
// ----------------------------------------------------------
`timescale 1ns/1ps

module handshake_decoder
	import link_pkg::*;
(
	input  logic       clk,
	input  logic       rst_l,
	input  logic       game_active,
	input  hnd_frame_t frame,
	input  logic       frame_valid,
	output logic       ack_received,
	output logic       ack_seq_received,
	output logic       opponent_lost,
	output logic       send_lost_ack
);
	logic is_ack;
	logic rx_seq;

	// upper nibble seq code, lower nibble type code
	assign rx_seq = seq_majority(frame[HND_FRAME_BITS-1 -: SEQ_CODE_BITS]);
	assign is_ack = type_is_ack(frame[TYPE_CODE_BITS-1:0]);

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			ack_received <= 1'b0;
			ack_seq_received <= 1'b0;
			opponent_lost <= 1'b0;
			send_lost_ack <= 1'b0;
		end else if (!game_active) begin
			// clears the sticky lost flag too
			ack_received <= 1'b0;
			ack_seq_received <= 1'b0;
			opponent_lost <= 1'b0;
			send_lost_ack <= 1'b0;
		end else begin
			ack_received <= 1'b0;
			send_lost_ack <= 1'b0;
			if (frame_valid) begin
				if (is_ack) begin
					ack_received <= 1'b1;
					ack_seq_received <= rx_seq;
				end else if (!opponent_lost) begin
					// only the first game over frame is acknowledged
					opponent_lost <= 1'b1;
					send_lost_ack <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/data_packet_tracker.sv ====
// ----------------------------------------------------------
// data packet sequence check, opponent state registers
// and the delayed ack countdown
// ----------------------------------------------------------
`timescale 1ns/1ps

module data_packet_tracker
	import link_pkg::*,
	       game_pkg::*;
(
	input  logic         clk,
	input  logic         rst_l,
	input  logic         game_active,
	input  logic         init_seq,
	input  data_packet_t packet,
	input  logic         packet_valid,
	output logic         update_opponent_data,
	output garbage_t     opponent_garbage,
	output tile_t        opponent_hold,
	output queue_t       opponent_queue,
	output playfield_t   opponent_playfield,
	output logic         send_ack,
	output logic         ack_seq
);
	logic rx_seq;
	logic seq_match;
	// flips once per accepted packet, ack_seq is init_seq xor this
	logic seq_flip;
	// nonzero while an ack is pending
	ack_cnt_t ack_cnt;

	// majority vote over the four copies of the seq bit
	assign rx_seq = seq_majority(code_t'(packet[PKT_SEQ_LSB +: SEQ_CODE_BITS]));
	assign seq_match = (rx_seq == ack_seq);
	assign ack_seq = init_seq ^ seq_flip;

	// opponent state and sequence tracking
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			update_opponent_data <= 1'b0;
			opponent_garbage <= '0;
			opponent_hold <= TILE_BLANK;
			opponent_queue <= {QUEUE_LEN{TILE_BLANK}};
			opponent_playfield <= {PF_ROWS*PF_COLS{TILE_BLANK}};
			seq_flip <= 1'b0;
		end else if (!game_active) begin
			// back to reset values between games
			update_opponent_data <= 1'b0;
			opponent_garbage <= '0;
			opponent_hold <= TILE_BLANK;
			opponent_queue <= {QUEUE_LEN{TILE_BLANK}};
			opponent_playfield <= {PF_ROWS*PF_COLS{TILE_BLANK}};
			seq_flip <= 1'b0;
		end else begin
			update_opponent_data <= 1'b0;
			if (packet_valid && seq_match) begin
				opponent_garbage <= packet[PKT_GBG_LSB +: GARBAGE_BITS];
				opponent_hold <= packet[PKT_HOLD_LSB +: TILE_BITS];
				opponent_queue <= packet[PKT_QUEUE_LSB +: QUEUE_BITS];
				opponent_playfield <= packet[PKT_PF_LSB +: PF_BITS];
				seq_flip <= ~seq_flip;
				update_opponent_data <= 1'b1;
			end
			// out of sequence packets are dropped here
		end
	end

	// ack timer
	// loaded on every valid packet, matched or not
	// a newer packet restarts the wait
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			ack_cnt <= '0;
			send_ack <= 1'b0;
		end else if (!game_active) begin
			ack_cnt <= '0;
			send_ack <= 1'b0;
		end else begin
			send_ack <= 1'b0;
			if (packet_valid) begin
				// pulse lands ACK_DELAY cycles after the accept cycle
				ack_cnt <= ack_cnt_t'(ACK_DELAY - 1);
			end else if (ack_cnt != '0) begin
				ack_cnt <= ack_cnt - 1'b1;
				if (ack_cnt == ack_cnt_t'(1)) begin
					send_ack <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/frame_sequencer.sv ====
// ----------------------------------------------------------
// start/rearm FSM for a group of deframers, frame_valid pulse
// ----------------------------------------------------------
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int LANES = 4
) (
	input  logic             clk,
	input  logic             rst_l,
	input  logic             game_active,
	input  logic [LANES-1:0] done_lanes,
	output logic             start,
	output logic             frame_valid
);
	typedef enum logic [1:0] {
		IDLE,
		HUNT,
		REARM
	} state_t;

	state_t state;

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			state <= IDLE;
		end else if (!game_active) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: state <= HUNT;
				// wait for the slowest lane
				HUNT: if (&done_lanes) state <= REARM;
				// one cycle with start low clears every deframer
				REARM: state <= HUNT;
				default: state <= IDLE;
			endcase
		end
	end

	assign start = (state == HUNT);
	// REARM is only entered from HUNT with all lanes done,
	// so this is the one-cycle pulse after done
	assign frame_valid = (state == REARM);

endmodule

// ==== hw/serial_deframer.sv ====
// ----------------------------------------------------------
// single lane sync word hunter and frame capture
// ----------------------------------------------------------
`timescale 1ns/1ps

module serial_deframer
	import link_pkg::*;
#(
	parameter int FRAME_BITS = 16
) (
	input  logic                  clk,
	input  logic                  rst_l,
	input  logic                  start,
	input  logic                  serial,
	output logic [FRAME_BITS-1:0] frame,
	output logic                  done
);
	typedef logic [$clog2(FRAME_BITS)-1:0] cnt_t;

	// sliding window over the last eight line bits
	sync_t window;
	sync_t window_next;
	// high between sync match and last payload bit
	logic capturing;
	cnt_t bit_cnt;

	assign window_next = {window[SYNC_BITS-2:0], serial};

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			window <= '0;
			capturing <= 1'b0;
			bit_cnt <= '0;
			done <= 1'b0;
		end else if (!start) begin
			// sequencer rearm, start the hunt over
			window <= '0;
			capturing <= 1'b0;
			bit_cnt <= '0;
			done <= 1'b0;
		end else if (capturing) begin
			bit_cnt <= bit_cnt + 1'b1;
			// last payload bit goes in on this edge
			if (bit_cnt == cnt_t'(FRAME_BITS - 1)) begin
				capturing <= 1'b0;
				done <= 1'b1;
			end
		end else if (!done) begin
			window <= window_next;
			// first payload bit follows on the next cycle
			if (window_next == SYNC_WORD) begin
				capturing <= 1'b1;
				bit_cnt <= '0;
			end
		end
	end

	// payload shift register, msb first
	// holds its value through done and the rearm gap
	always_ff @(posedge clk) begin
		if (start && capturing) begin
			frame <= {frame[FRAME_BITS-2:0], serial};
		end
	end

endmodule

// ==== hw/game_pkg.sv ====
// ----------------------------------------------------------
// opponent state field sizes, tile type, packet field offsets
// ----------------------------------------------------------
package game_pkg;

	localparam int TILE_BITS = 4;
	localparam int GARBAGE_BITS = 4;
	localparam int QUEUE_LEN = 3;
	localparam int PF_ROWS = 2;
	localparam int PF_COLS = 5;

	localparam int QUEUE_BITS = TILE_BITS * QUEUE_LEN;
	localparam int PF_BITS = TILE_BITS * PF_ROWS * PF_COLS;

	typedef logic [TILE_BITS-1:0] tile_t;
	typedef logic [GARBAGE_BITS-1:0] garbage_t;
	// tile i at bits 4i upward
	typedef logic [QUEUE_BITS-1:0] queue_t;
	// cell (r,c) at bits 4*(5r+c) upward
	typedef logic [PF_BITS-1:0] playfield_t;

	localparam tile_t TILE_BLANK = tile_t'(0);

	// packet layout, msb down: seq, garbage, hold, queue, playfield
	localparam int PKT_PF_LSB = 0;
	localparam int PKT_QUEUE_LSB = PKT_PF_LSB + PF_BITS;
	localparam int PKT_HOLD_LSB = PKT_QUEUE_LSB + QUEUE_BITS;
	localparam int PKT_GBG_LSB = PKT_HOLD_LSB + TILE_BITS;
	localparam int PKT_SEQ_LSB = PKT_GBG_LSB + GARBAGE_BITS;

endpackage

// ==== hw/link_pkg.sv ====
// ----------------------------------------------------------
// serial link framing constants, frame and packet vectors
// and the majority decoders for the sequence and type codes
// ----------------------------------------------------------
package link_pkg;

	// sync word precedes every frame on every lane
	localparam int SYNC_BITS = 8;
	localparam logic [SYNC_BITS-1:0] SYNC_WORD = 8'hD2;

	localparam int DATA_LANES = 4;
	localparam int DATA_FRAME_BITS = 16;
	localparam int HND_FRAME_BITS = 8;

	// 4-bit redundant codes in the handshake frame and the packet head
	localparam int SEQ_CODE_BITS = 4;
	localparam int TYPE_CODE_BITS = 4;

	// cycles from packet accept to ack request
	localparam int ACK_DELAY = 50;

	typedef logic [SYNC_BITS-1:0] sync_t;
	typedef logic [DATA_LANES-1:0] lanes_t;
	typedef logic [DATA_FRAME_BITS-1:0] data_frame_t;
	// seq code in the upper nibble, type code in the lower
	typedef logic [HND_FRAME_BITS-1:0] hnd_frame_t;
	// lane 0 sits in the top 16 bits
	typedef logic [DATA_LANES*DATA_FRAME_BITS-1:0] data_packet_t;
	typedef logic [SEQ_CODE_BITS-1:0] code_t;
	typedef logic [$clog2(ACK_DELAY)-1:0] ack_cnt_t;

	// seq bit is 1 when two or more of the four copies are set
	function automatic logic seq_majority(input code_t code);
		logic [2:0] ones;
		ones = '0;
		for (int i = 0; i < SEQ_CODE_BITS; i++) begin
			ones = ones + 3'(code[i]);
		end
		return ones >= 3'd2;
	endfunction

	// any set bit means ack, all zeros means game over
	function automatic logic type_is_ack(input code_t code);
		return |code;
	endfunction

endpackage
